// File: project.f
ioPlatformPkg.sv
ioAddrDecoder.sv
ioErrorSink.sv
clintTimer.sv
plicGateway.sv
plicCore.sv
ioPlatformTop.sv
tbClockGen.sv
ioPlatformTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ioPlatformTb
LOG       ?= sim.log
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) --binary -j 0 --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: ioPlatformTb.sv
module ioPlatformTb import ioPlatformPkg::*; #(
  parameter int NumHarts = 2,
  parameter int NumIrqs  = 8
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RspTimeout   = 20;
  localparam int ResetTimeout = 50;
  localparam int Skip         = -1;

  typedef logic [NumHarts-1:0] hartVecT;

  typedef enum logic [1:0] {
    DataEq,
    DataSkip,
    DataAbove
  } dataModeE;

  // one stimulus row with its expected response
  typedef struct packed {
    logic     write;
    ioAddrT   addr;
    ioDataT   wdata;
    logic     uart;
    logic     sd;
    dataModeE dataMode;
    ioDataT   expData;
    logic     expErr;
    int       expExt;
    int       expMsip;
    int       expMtip;
  } rowT;

  //////////////////////////////
  // register addresses

  localparam ioAddrT UartAddr = 32'h1000_0000;
  localparam ioAddrT SdAddr   = 32'h1001_0000;
  localparam ioAddrT Msip1    = ClintBase + ClintMsipOff + 32'h8;
  localparam ioAddrT Cmp0     = ClintBase + ClintCmpOff;
  localparam ioAddrT Mtime    = ClintBase + ClintTimeOff;
  localparam ioAddrT Prio1    = PlicBase + PlicPrioOff + 32'h8;
  localparam ioAddrT Prio2    = PlicBase + PlicPrioOff + 32'h10;
  localparam ioAddrT Pend     = PlicBase + PlicPendOff;
  localparam ioAddrT En0      = PlicBase + PlicEnOff;
  localparam ioAddrT En1      = PlicBase + PlicEnOff + 32'h80;
  localparam ioAddrT Thr0     = PlicBase + PlicThrOff;
  localparam ioAddrT Claim0   = PlicBase + PlicClaimOff;
  localparam ioAddrT Claim1   = PlicBase + PlicClaimOff + 32'h1000;

  logic    clk;
  logic    arstN;
  logic    reqValid;
  logic    reqWrite;
  ioAddrT  reqAddr;
  ioDataT  reqWdata;
  logic    uartIrq;
  logic    sdIrq;
  logic    rspValid;
  ioDataT  rspData;
  logic    rspErr;
  hartVecT msip;
  hartVecT mtip;
  hartVecT extIrq;

  rowT    rows[$];
  string  rowNames[$];
  ioDataT lastData;
  int     checks;
  int     errors;
  int     timeouts;

  tbClockGen #(
    .PeriodNs    (8),
    .ResetCycles (10)
  ) clockGen (
    .clk_o   (clk),
    .arstN_o (arstN)
  );

  ioPlatformTop #(
    .NumHarts (NumHarts),
    .NumIrqs  (NumIrqs)
  ) dut (
    .clk_i      (clk),
    .arstN_i    (arstN),
    .reqValid_i (reqValid),
    .reqWrite_i (reqWrite),
    .reqAddr_i  (reqAddr),
    .reqWdata_i (reqWdata),
    .uartIrq_i  (uartIrq),
    .sdIrq_i    (sdIrq),
    .rspValid_o (rspValid),
    .rspData_o  (rspData),
    .rspErr_o   (rspErr),
    .msip_o     (msip),
    .mtip_o     (mtip),
    .extIrq_o   (extIrq)
  );

  //////////////////////////////
  // compare tasks

  task automatic checkData(string name, ioDataT expVal, ioDataT actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("Fail %s: expected 0x%016h, actual 0x%016h", name, expVal, actVal);
    end
  endtask

  task automatic checkDataAbove(string name, ioDataT floorVal, ioDataT actVal);
    checks++;
    if (!(actVal > floorVal)) begin
      errors++;
      $display("Fail %s: expected above 0x%016h, actual 0x%016h", name, floorVal, actVal);
    end
  endtask

  task automatic checkFlag(string name, logic expVal, logic actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("Fail %s: expected %b, actual %b", name, expVal, actVal);
    end
  endtask

  task automatic checkIrqVec(string name, hartVecT expVal, hartVecT actVal);
    checks++;
    if (actVal !== expVal) begin
      errors++;
      $display("Fail %s: expected %b, actual %b", name, expVal, actVal);
    end
  endtask

  //////////////////////////////
  // stimulus table

  task automatic addRow(string name, int write, ioAddrT addr, ioDataT wdata, int uart,
                        int sd, dataModeE mode, ioDataT expData, int expErr,
                        int expExt, int expMsip, int expMtip);
    rowT r;
    r.write    = (write != 0);
    r.addr     = addr;
    r.wdata    = wdata;
    r.uart     = (uart != 0);
    r.sd       = (sd != 0);
    r.dataMode = mode;
    r.expData  = expData;
    r.expErr   = (expErr != 0);
    r.expExt   = expExt;
    r.expMsip  = expMsip;
    r.expMtip  = expMtip;
    rows.push_back(r);
    rowNames.push_back(name);
  endtask

  // columns are name, write, addr, wdata, uart, sd, mode, data, err, ext, msip, mtip
  task automatic buildTable();
    addRow("prio1 after reset", 0, Prio1, 64'h0, 0, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    addRow("enable0 after reset", 0, En0, 64'h0, 0, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    addRow("thr0 after reset", 0, Thr0, 64'h0, 0, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    addRow("pending after reset", 0, Pend, 64'h0, 0, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    addRow("claim0 empty", 0, Claim0, 64'h0, 0, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    // former uart and sd regions land in the error sink
    addRow("uart region read", 0, UartAddr, 64'h0, 0, 0, DataEq, 64'h0, 1, 0, 0, Skip);
    addRow("uart region write", 1, UartAddr, 64'h55, 0, 0, DataEq, 64'h0, 1, 0, 0, Skip);
    addRow("sd region read", 0, SdAddr, 64'h0, 0, 0, DataEq, 64'h0, 1, 0, 0, Skip);
    addRow("sd region write", 1, SdAddr, 64'hAA, 0, 0, DataEq, 64'h0, 1, 0, 0, Skip);
    addRow("msip1 set", 1, Msip1, 64'h1, 0, 0, DataEq, 64'h0, 0, 0, 2, Skip);
    addRow("msip1 read", 0, Msip1, 64'h0, 0, 0, DataEq, 64'h1, 0, 0, 2, Skip);
    addRow("msip1 clear", 1, Msip1, 64'h0, 0, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    // hart 1 compare stays at reset zero, so its bit stays high
    addRow("mtimecmp0 max", 1, Cmp0, '1, 0, 0, DataEq, 64'h0, 0, 0, 0, 2);
    addRow("mtimecmp0 read", 0, Cmp0, 64'h0, 0, 0, DataEq, '1, 0, 0, 0, 2);
    addRow("mtimecmp0 zero", 1, Cmp0, 64'h0, 0, 0, DataEq, 64'h0, 0, 0, 0, 3);
    addRow("mtime first", 0, Mtime, 64'h0, 0, 0, DataSkip, 64'h0, 0, 0, 0, Skip);
    addRow("mtime second", 0, Mtime, 64'h0, 0, 0, DataAbove, 64'h0, 0, 0, 0, Skip);
    addRow("prio1 write", 1, Prio1, 64'h2, 0, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    addRow("prio2 write", 1, Prio2, 64'h5, 0, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    addRow("prio2 read", 0, Prio2, 64'h0, 0, 0, DataEq, 64'h5, 0, 0, 0, Skip);
    addRow("enable0 write", 1, En0, 64'h6, 0, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    addRow("thr0 zero", 1, Thr0, 64'h0, 0, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    // reads sample pending before the edge that accepts them
    addRow("uart raise", 0, Prio1, 64'h0, 1, 0, DataEq, 64'h2, 0, 1, 0, Skip);
    addRow("uart pending", 0, Pend, 64'h0, 1, 0, DataEq, 64'h2, 0, 1, 0, Skip);
    addRow("uart claim", 0, Claim0, 64'h0, 1, 0, DataEq, 64'h1, 0, 0, 0, Skip);
    addRow("uart held in flight", 0, Pend, 64'h0, 1, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    addRow("uart complete", 1, Claim0, 64'h1, 1, 0, DataEq, 64'h0, 0, 0, 0, Skip);
    addRow("uart repends", 0, Prio1, 64'h0, 1, 0, DataEq, 64'h2, 0, 1, 0, Skip);
    addRow("both raised", 0, Pend, 64'h0, 1, 1, DataEq, 64'h2, 0, 1, 0, Skip);
    addRow("sd wins claim", 0, Claim0, 64'h0, 1, 1, DataEq, 64'h2, 0, 1, 0, Skip);
    addRow("sd complete", 1, Claim0, 64'h2, 1, 1, DataEq, 64'h0, 0, 1, 0, Skip);
    addRow("thr0 five", 1, Thr0, 64'h5, 1, 1, DataEq, 64'h0, 0, 0, 0, Skip);
    addRow("sd pending masked", 0, Pend, 64'h0, 1, 1, DataEq, 64'h6, 0, 0, 0, Skip);
    addRow("thr0 four", 1, Thr0, 64'h4, 1, 1, DataEq, 64'h0, 0, 1, 0, Skip);
    addRow("thr0 read", 0, Thr0, 64'h0, 1, 1, DataEq, 64'h4, 0, 1, 0, Skip);
    addRow("enable1 empty", 0, En1, 64'h0, 1, 1, DataEq, 64'h0, 0, 1, 0, Skip);
    addRow("claim1 empty", 0, Claim1, 64'h0, 1, 1, DataEq, 64'h0, 0, 1, 0, Skip);
  endtask

  //////////////////////////////
  // row driver

  task automatic applyRow(int idx);
    rowT   r;
    string name;
    int    waited;
    r    = rows[idx];
    name = rowNames[idx];
    @(posedge clk);
    #1;
    reqValid = 1'b1;
    reqWrite = r.write;
    reqAddr  = r.addr;
    reqWdata = r.wdata;
    uartIrq  = r.uart;
    sdIrq    = r.sd;
    @(posedge clk);
    #1;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    waited   = 0;
    while (!rspValid && waited < RspTimeout) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!rspValid) begin
      timeouts++;
      $display("%s: no response arrived within %0d cycles", name, RspTimeout);
    end else begin
      if (waited != 0) begin
        errors++;
        $display("Fail %s: expected latency 1, actual %0d", name, waited + 1);
      end
      checkFlag({name, " rspErr"}, r.expErr, rspErr);
      if (r.dataMode == DataEq) begin
        checkData({name, " rspData"}, r.expData, rspData);
      end else if (r.dataMode == DataAbove) begin
        checkDataAbove({name, " rspData"}, lastData, rspData);
      end
      lastData = rspData;
      if (r.expExt != Skip) begin
        checkIrqVec({name, " extIrq"}, hartVecT'(r.expExt), extIrq);
      end
      if (r.expMsip != Skip) begin
        checkIrqVec({name, " msip"}, hartVecT'(r.expMsip), msip);
      end
      if (r.expMtip != Skip) begin
        checkIrqVec({name, " mtip"}, hartVecT'(r.expMtip), mtip);
      end
    end
  endtask

  //////////////////////////////
  // main sequence

  initial begin
    int waited;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr  = '0;
    reqWdata = '0;
    uartIrq  = 1'b0;
    sdIrq    = 1'b0;
    lastData = '0;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    buildTable();

    waited = 0;
    while (arstN !== 1'b1 && waited < ResetTimeout) begin
      @(posedge clk);
      waited++;
    end
    if (arstN !== 1'b1) begin
      timeouts++;
      $display("reset was not released within %0d cycles", ResetTimeout);
    end

    // idle state right after reset
    @(posedge clk);
    #1;
    checkFlag("reset rspValid", 1'b0, rspValid);
    checkIrqVec("reset msip", '0, msip);
    checkIrqVec("reset extIrq", '0, extIrq);

    for (int i = 0; i < rows.size(); i++) begin
      applyRow(i);
    end

    $display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: tbClockGen.sv
module tbClockGen #(
  parameter int PeriodNs    = 8,
  parameter int ResetCycles = 10
) (
  output logic clk_o,
  output logic arstN_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2);
      clk_o = ~clk_o;
    end
  end

  // release just after an edge, away from the sampling point
  initial begin
    arstN_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    arstN_o = 1'b1;
  end

endmodule

// File: ioPlatformTop.sv
module ioPlatformTop import ioPlatformPkg::*; #(
  parameter int NumHarts = 2,
  parameter int NumIrqs  = 8
) (
  input  logic                clk_i,
  input  logic                arstN_i,
  input  logic                reqValid_i,
  input  logic                reqWrite_i,
  input  ioAddrT              reqAddr_i,
  input  ioDataT              reqWdata_i,
  input  logic                uartIrq_i,
  input  logic                sdIrq_i,

  output logic                rspValid_o,
  output ioDataT              rspData_o,
  output logic                rspErr_o,
  output logic [NumHarts-1:0] msip_o,
  output logic [NumHarts-1:0] mtip_o,
  output logic [NumHarts-1:0] extIrq_o
);

  logic   errReq;
  logic   clintReq;
  logic   plicReq;
  ioDataT errRdata;
  ioDataT clintRdata;
  ioDataT plicRdata;
  logic   errFlag;

  logic [NumIrqs-1:0] irqLines;
  logic [NumIrqs-1:0] pending;
  logic [NumIrqs-1:0] claim;
  logic [NumIrqs-1:0] complete;

  //////////////////////////////
  // address switch

  ioAddrDecoder decoder (
    .clk_i,
    .arstN_i,
    .reqValid_i,
    .reqAddr_i,
    .errReq_o     (errReq),
    .clintReq_o   (clintReq),
    .plicReq_o    (plicReq),
    .errRdata_i   (errRdata),
    .clintRdata_i (clintRdata),
    .plicRdata_i  (plicRdata),
    .errFlag_i    (errFlag),
    .rspValid_o,
    .rspData_o,
    .rspErr_o
  );

  ioErrorSink errorSink (
    .clk_i,
    .arstN_i,
    .req_i     (errReq),
    .rdata_o   (errRdata),
    .errFlag_o (errFlag)
  );

  //////////////////////////////
  // clint and plic

  clintTimer #(
    .NumHarts (NumHarts)
  ) clint (
    .clk_i,
    .arstN_i,
    .req_i   (clintReq),
    .write_i (reqWrite_i),
    .addr_i  (reqAddr_i),
    .wdata_i (reqWdata_i),
    .rdata_o (clintRdata),
    .msip_o,
    .mtip_o
  );

  plicGateway #(
    .NumIrqs (NumIrqs)
  ) gateway (
    .clk_i,
    .arstN_i,
    .irqLevel_i (irqLines),
    .claim_i    (claim),
    .complete_i (complete),
    .pending_o  (pending)
  );

  plicCore #(
    .NumHarts (NumHarts),
    .NumIrqs  (NumIrqs)
  ) plic (
    .clk_i,
    .arstN_i,
    .req_i      (plicReq),
    .write_i    (reqWrite_i),
    .addr_i     (reqAddr_i),
    .wdata_i    (reqWdata_i),
    .pending_i  (pending),
    .claim_o    (claim),
    .complete_o (complete),
    .rdata_o    (plicRdata),
    .extIrq_o
  );

  //////////////////////////////
  // irq routing

  // both sources are level triggered, unused lines stay low
  always_comb begin
    irqLines    = '0;
    irqLines[1] = uartIrq_i;
    irqLines[2] = sdIrq_i;
  end

endmodule

// File: plicCore.sv
module plicCore import ioPlatformPkg::*; #(
  parameter int NumHarts = 2,
  parameter int NumIrqs  = 8
) (
  input  logic                clk_i,
  input  logic                arstN_i,
  input  logic                req_i,
  input  logic                write_i,
  input  ioAddrT              addr_i,
  input  ioDataT              wdata_i,
  input  logic [NumIrqs-1:0]  pending_i,

  output logic [NumIrqs-1:0]  claim_o,
  output logic [NumIrqs-1:0]  complete_o,
  output ioDataT              rdata_o,
  output logic [NumHarts-1:0] extIrq_o
);

  localparam int IdW = $clog2(NumIrqs);

  ioAddrT              off;
  logic [NumIrqs-1:0]  prioSel;
  logic                pendSel;
  logic [NumHarts-1:0] enSel;
  logic [NumHarts-1:0] thrSel;
  logic [NumHarts-1:0] claimSel;

  logic [PrioWidth-1:0] prioQ [NumIrqs];
  logic [NumIrqs-1:0]   enQ [NumHarts];
  logic [PrioWidth-1:0] thrQ [NumHarts];

  logic [IdW-1:0]       bestId [NumHarts];
  logic [PrioWidth-1:0] bestPrio [NumHarts];

  ioDataT rdNext;
  ioDataT rdataQ;

  //////////////////////////////
  // register decode

  assign off = addr_i & PlicMask;
  assign pendSel = off == PlicPendOff;

  always_comb begin
    for (int s = 0; s < NumIrqs; s++) begin
      prioSel[s] = off == PlicPrioOff + ioAddrT'(8 * s);
    end
    for (int c = 0; c < NumHarts; c++) begin
      enSel[c]    = off == PlicEnOff + ioAddrT'(32'h80 * c);
      thrSel[c]   = off == PlicThrOff + ioAddrT'(32'h1000 * c);
      claimSel[c] = off == PlicClaimOff + ioAddrT'(32'h1000 * c);
    end
  end

  //////////////////////////////
  // configuration registers

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      for (int s = 0; s < NumIrqs; s++) begin
        prioQ[s] <= '0;
      end
      for (int c = 0; c < NumHarts; c++) begin
        enQ[c]  <= '0;
        thrQ[c] <= '0;
      end
    end else if (req_i && write_i) begin
      // source 0 has no priority and stays at zero
      for (int s = 1; s < NumIrqs; s++) begin
        if (prioSel[s]) begin
          prioQ[s] <= wdata_i[PrioWidth-1:0];
        end
      end
      for (int c = 0; c < NumHarts; c++) begin
        if (enSel[c]) begin
          enQ[c] <= wdata_i[NumIrqs-1:0];
        end
        if (thrSel[c]) begin
          thrQ[c] <= wdata_i[PrioWidth-1:0];
        end
      end
    end
  end

  //////////////////////////////
  // arbitration per context

  // strict compare keeps the lower id on a tie and skips priority 0
  always_comb begin
    for (int c = 0; c < NumHarts; c++) begin
      bestId[c]   = '0;
      bestPrio[c] = '0;
      for (int s = 1; s < NumIrqs; s++) begin
        if (pending_i[s] && enQ[c][s] && prioQ[s] > bestPrio[c]) begin
          bestId[c]   = IdW'(s);
          bestPrio[c] = prioQ[s];
        end
      end
      extIrq_o[c] = bestPrio[c] > thrQ[c];
    end
  end

  // claim on read, complete on write of the same register
  always_comb begin
    claim_o    = '0;
    complete_o = '0;
    for (int c = 0; c < NumHarts; c++) begin
      if (req_i && claimSel[c]) begin
        if (write_i) begin
          if (wdata_i < ioDataT'(NumIrqs)) begin
            complete_o[wdata_i[IdW-1:0]] = 1'b1;
          end
        end else if (bestId[c] != '0) begin
          claim_o[bestId[c]] = 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // read path

  always_comb begin
    rdNext = '0;
    if (!write_i) begin
      for (int s = 0; s < NumIrqs; s++) begin
        if (prioSel[s]) begin
          rdNext = ioDataT'(prioQ[s]);
        end
      end
      if (pendSel) begin
        rdNext = ioDataT'(pending_i);
      end
      for (int c = 0; c < NumHarts; c++) begin
        if (enSel[c]) begin
          rdNext = ioDataT'(enQ[c]);
        end
        if (thrSel[c]) begin
          rdNext = ioDataT'(thrQ[c]);
        end
        if (claimSel[c]) begin
          rdNext = ioDataT'(bestId[c]);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdataQ <= rdNext;
    end
  end

  assign rdata_o = rdataQ;

endmodule

// File: plicGateway.sv
module plicGateway #(
  parameter int NumIrqs = 8
) (
  input  logic               clk_i,
  input  logic               arstN_i,
  input  logic [NumIrqs-1:0] irqLevel_i,
  input  logic [NumIrqs-1:0] claim_i,
  input  logic [NumIrqs-1:0] complete_i,

  output logic [NumIrqs-1:0] pending_o
);

  logic [NumIrqs-1:0] pendingQ;
  logic [NumIrqs-1:0] inFlightQ;
  logic [NumIrqs-1:0] pendingNext;
  logic [NumIrqs-1:0] inFlightNext;

  // level sets pending unless the source is already being serviced
  assign pendingNext  = (pendingQ | (irqLevel_i & ~inFlightQ)) & ~claim_i;

  // a claim moves the source into flight, completion releases it
  assign inFlightNext = (inFlightQ | claim_i) & ~complete_i;

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      pendingQ  <= '0;
      inFlightQ <= '0;
    end else begin
      pendingQ  <= pendingNext;
      inFlightQ <= inFlightNext;
    end
  end

  assign pending_o = pendingQ;

endmodule

// File: clintTimer.sv
module clintTimer import ioPlatformPkg::*; #(
  parameter int NumHarts = 2
) (
  input  logic                clk_i,
  input  logic                arstN_i,
  input  logic                req_i,
  input  logic                write_i,
  input  ioAddrT              addr_i,
  input  ioDataT              wdata_i,

  output ioDataT              rdata_o,
  output logic [NumHarts-1:0] msip_o,
  output logic [NumHarts-1:0] mtip_o
);

  ioAddrT              off;
  logic [NumHarts-1:0] msipSel;
  logic [NumHarts-1:0] cmpSel;
  logic                timeSel;
  ioDataT              rdNext;

  logic [NumHarts-1:0] msipQ;
  ioDataT              cmpQ [NumHarts];
  ioDataT              mtimeQ;
  ioDataT              rdataQ;

  //////////////////////////////
  // register decode

  assign off = addr_i & ClintMask;

  always_comb begin
    for (int h = 0; h < NumHarts; h++) begin
      msipSel[h] = off == ClintMsipOff + ioAddrT'(8 * h);
      cmpSel[h]  = off == ClintCmpOff + ioAddrT'(8 * h);
    end
    timeSel = off == ClintTimeOff;
  end

  //////////////////////////////
  // state

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      msipQ  <= '0;
      mtimeQ <= '0;
      for (int h = 0; h < NumHarts; h++) begin
        cmpQ[h] <= '0;
      end
    end else begin
      // a load of mtime wins over the count
      if (req_i && write_i && timeSel) begin
        mtimeQ <= wdata_i;
      end else begin
        mtimeQ <= mtimeQ + 64'd1;
      end
      for (int h = 0; h < NumHarts; h++) begin
        if (req_i && write_i && msipSel[h]) begin
          msipQ[h] <= wdata_i[0];
        end
        if (req_i && write_i && cmpSel[h]) begin
          cmpQ[h] <= wdata_i;
        end
      end
    end
  end

  //////////////////////////////
  // read path

  always_comb begin
    rdNext = '0;
    if (!write_i) begin
      for (int h = 0; h < NumHarts; h++) begin
        if (msipSel[h]) begin
          rdNext = ioDataT'(msipQ[h]);
        end
        if (cmpSel[h]) begin
          rdNext = cmpQ[h];
        end
      end
      if (timeSel) begin
        rdNext = mtimeQ;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdataQ <= rdNext;
    end
  end

  assign rdata_o = rdataQ;
  assign msip_o  = msipQ;

  // timer pending while mtime has reached the compare value
  always_comb begin
    for (int h = 0; h < NumHarts; h++) begin
      mtip_o[h] = mtimeQ >= cmpQ[h];
    end
  end

endmodule

// File: ioErrorSink.sv
module ioErrorSink import ioPlatformPkg::*; (
  input  logic   clk_i,
  input  logic   arstN_i,
  input  logic   req_i,

  output ioDataT rdata_o,
  output logic   errFlag_o
);

  logic errQ;

  // flag follows each strobe by one cycle
  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      errQ <= 1'b0;
    end else begin
      errQ <= req_i;
    end
  end

  // unmapped space reads as zero
  assign rdata_o   = '0;
  assign errFlag_o = errQ;

endmodule

// File: ioAddrDecoder.sv
module ioAddrDecoder import ioPlatformPkg::*; (
  input  logic   clk_i,
  input  logic   arstN_i,
  input  logic   reqValid_i,
  input  ioAddrT reqAddr_i,

  output logic   errReq_o,
  output logic   clintReq_o,
  output logic   plicReq_o,

  input  ioDataT errRdata_i,
  input  ioDataT clintRdata_i,
  input  ioDataT plicRdata_i,
  input  logic   errFlag_i,

  output logic   rspValid_o,
  output ioDataT rspData_o,
  output logic   rspErr_o
);

  ioDevE devSel;
  ioDevE selQ;
  logic  validQ;

  function automatic logic inRegion(ioAddrT addr, ioAddrT base, ioAddrT mask);
    return (addr & ~mask) == base;
  endfunction

  //////////////////////////////
  // request side

  // anything outside the two regions falls to the error sink
  always_comb begin
    devSel = DevErr;
    if (inRegion(reqAddr_i, ClintBase, ClintMask)) begin
      devSel = DevClint;
    end else if (inRegion(reqAddr_i, PlicBase, PlicMask)) begin
      devSel = DevPlic;
    end
  end

  assign errReq_o   = reqValid_i && (devSel == DevErr);
  assign clintReq_o = reqValid_i && (devSel == DevClint);
  assign plicReq_o  = reqValid_i && (devSel == DevPlic);

  //////////////////////////////
  // response side

  always_ff @(posedge clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      validQ <= 1'b0;
      selQ   <= DevErr;
    end else begin
      validQ <= reqValid_i;
      if (reqValid_i) begin
        selQ <= devSel;
      end
    end
  end

  always_comb begin
    case (selQ)
      DevClint: rspData_o = clintRdata_i;
      DevPlic:  rspData_o = plicRdata_i;
      default:  rspData_o = errRdata_i;
    endcase
  end

  assign rspValid_o = validQ;
  // only the sink can flag an error
  assign rspErr_o   = (selQ == DevErr) && errFlag_i;

endmodule

// File: ioPlatformPkg.sv
package ioPlatformPkg;

  //////////////////////////////
  // bus types

  typedef logic [31:0] ioAddrT;
  typedef logic [63:0] ioDataT;

  // responder select, error sink is the default target
  typedef enum logic [1:0] {
    DevErr,
    DevClint,
    DevPlic
  } ioDevE;

  //////////////////////////////
  // region map

  localparam ioAddrT ClintBase = 32'h1140_0000;
  localparam ioAddrT ClintMask = 32'h0000_FFFF;

  localparam ioAddrT PlicBase  = 32'h1100_0000;
  localparam ioAddrT PlicMask  = 32'h003F_FFFF;

  //////////////////////////////
  // clint offsets

  // msip and mtimecmp have a hart stride of 8
  localparam ioAddrT ClintMsipOff = 32'h0000_0000;
  localparam ioAddrT ClintCmpOff  = 32'h0000_4000;
  localparam ioAddrT ClintTimeOff = 32'h0000_BFF8;

  //////////////////////////////
  // plic offsets

  localparam ioAddrT PlicPrioOff  = 32'h0000_0000;
  localparam ioAddrT PlicPendOff  = 32'h0000_1000;
  // enable stride 0x80 per context
  localparam ioAddrT PlicEnOff    = 32'h0000_2000;
  // threshold and claim stride 0x1000 per context
  localparam ioAddrT PlicThrOff   = 32'h0020_0000;
  localparam ioAddrT PlicClaimOff = 32'h0020_0008;

  // priority and threshold width
  localparam int PrioWidth = 3;

endpackage
